//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = oramBucketEncryptorTb
FILELIST  = project.f
OBJDIR    = obj_dir
SIMARGS   = +verilator+error+limit+1000
PASS_MSG  = Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP) $(SIMARGS)); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- include/oram_settings.svh
`ifndef ORAM_SETTINGS_SVH
`define ORAM_SETTINGS_SVH

// cipher datapath
`define ORAM_CIPHER_W   128
`define ORAM_ROUNDS     4     // one pipeline stage per round

// application side
`define ORAM_BLOCK_W    256   // two cipher lanes
`define ORAM_ADDR_W     20
`define ORAM_LEAF_W     12

// bucket geometry
`define ORAM_BUCKET_Z   3     // blocks per bucket

// DRAM side
`define ORAM_DRAM_W     64
`define ORAM_BEATS      16    // beats per bucket, 1024 bits total

`endif

//--- project.f
+incdir+include
src/oramPkg.sv
src/bucketCollector.sv
src/bucketCipher.sv
src/bucketSerializer.sv
src/oramBucketEncryptor.sv
verif/oramBucketEncryptor_assertions.sv
verif/oramBucketEncryptorTb.sv

//--- src/bucketCipher.sv
`timescale 1ns/1ps
`include "oram_settings.svh"

module bucketCipher
    import oramPkg::*;
(
    input  logic          Clock,
    input  logic          rstN,

    input  cipherWord_t   cipherKey,

    input  logic          plainValid,
    input  plainBucket_t  plainBucket,

    output logic          cipherValid,
    output cipherBucket_t cipherBucket
);

    localparam int lanesPerBlock = `ORAM_BLOCK_W / `ORAM_CIPHER_W;
    localparam int laneCount     = 1 + `ORAM_BUCKET_Z * lanesPerBlock;
    localparam int lastStage     = `ORAM_ROUNDS - 1;
    localparam int hdrW          = $bits(blockHeader_t);

    // ks[r][k] holds lane k after r+1 rounds
    cipherWord_t  ks [`ORAM_ROUNDS][laneCount];
    plainBucket_t plainPipe [`ORAM_ROUNDS];
    logic [`ORAM_ROUNDS-1:0] validPipe;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN)
            validPipe <= '0;
        else
            validPipe <= {validPipe[`ORAM_ROUNDS-2:0], plainValid};
    end

    // lane 0 is the header, lane k counts from iv + k
    always_ff @(posedge Clock) begin
        for (int k = 0; k < laneCount; k++) begin
            ks[0][k] <= cipherRound(plainBucket.iv + cipherWord_t'(k), cipherKey, 0);
            for (int r = 1; r < `ORAM_ROUNDS; r++) begin
                ks[r][k] <= cipherRound(ks[r-1][k], cipherKey, r);
            end
        end
    end

    always_ff @(posedge Clock) begin
        plainPipe[0] <= plainBucket;
        for (int r = 1; r < `ORAM_ROUNDS; r++) begin
            plainPipe[r] <= plainPipe[r-1];
        end
    end

    always_comb begin
        cipherWord_t hdrWord;
        hdrWord = '0;   // zero padding above the three headers
        for (int i = 0; i < `ORAM_BUCKET_Z; i++) begin
            hdrWord[i*hdrW +: hdrW] = plainPipe[lastStage].hdr[i];
        end

        cipherBucket.iv      = plainPipe[lastStage].iv;   // stays in clear
        cipherBucket.hdrWord = hdrWord ^ ks[lastStage][0];
        for (int i = 0; i < `ORAM_BUCKET_Z; i++) begin
            for (int j = 0; j < lanesPerBlock; j++) begin
                cipherBucket.data[i][j*`ORAM_CIPHER_W +: `ORAM_CIPHER_W] =
                    plainPipe[lastStage].data[i][j*`ORAM_CIPHER_W +: `ORAM_CIPHER_W]
                    ^ ks[lastStage][1 + i*lanesPerBlock + j];
            end
        end
    end

    assign cipherValid = validPipe[lastStage];

endmodule

//--- src/bucketCollector.sv
`timescale 1ns/1ps
`include "oram_settings.svh"

module bucketCollector
    import oramPkg::*;
(
    input  logic         Clock,
    input  logic         rstN,

    input  logic         ivValid,
    input  cipherWord_t  ivIn,

    input  logic         blockValid,
    input  dataBlock_t   dataIn,
    input  progAddr_t    addrIn,
    input  leafLabel_t   leafIn,

    output logic         plainValid,
    output plainBucket_t plainBucket
);

    localparam int cntW = $clog2(`ORAM_BUCKET_Z);
    localparam logic [cntW-1:0] lastSlot = cntW'(`ORAM_BUCKET_Z - 1);

    cipherWord_t     ivReg;
    logic [cntW-1:0] blkCnt;   // slot for the next block
    plainBucket_t    bucketReg;
    logic            lastBlock;

    assign lastBlock = blockValid && (blkCnt == lastSlot);

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            ivReg      <= '0;
            blkCnt     <= '0;
            plainValid <= 1'b0;
        end else begin
            if (ivValid)
                ivReg <= ivIn;   // takes effect for the next bucket
            if (blockValid)
                blkCnt <= lastBlock ? '0 : blkCnt + 1'b1;
            plainValid <= lastBlock;
        end
    end

    // slot storage, overwritten block by block
    always_ff @(posedge Clock) begin
        if (blockValid) begin
            bucketReg.hdr[blkCnt]  <= '{addr: addrIn, leaf: leafIn};
            bucketReg.data[blkCnt] <= dataIn;
        end
        if (lastBlock)
            bucketReg.iv <= ivReg;  // iv as it stands on the closing block
    end

    assign plainBucket = bucketReg;

endmodule

//--- src/bucketSerializer.sv
`timescale 1ns/1ps
`include "oram_settings.svh"

module bucketSerializer
    import oramPkg::*;
(
    input  logic          Clock,
    input  logic          rstN,

    input  logic          cipherValid,
    input  cipherBucket_t cipherBucket,

    output logic          dramValid,
    output dramBeat_t     dramData
);

    localparam int beatW = $clog2(`ORAM_BEATS);
    localparam logic [beatW-1:0] finalBeat = beatW'(`ORAM_BEATS - 1);

    logic [$bits(cipherBucket_t)-1:0] shiftReg;
    logic [beatW-1:0]                 beatCnt;

    // a fresh bucket restarts the burst
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            dramValid <= 1'b0;
            beatCnt   <= '0;
        end else if (cipherValid) begin
            dramValid <= 1'b1;
            beatCnt   <= '0;
        end else if (dramValid) begin
            beatCnt <= beatCnt + 1'b1;
            if (beatCnt == finalBeat)
                dramValid <= 1'b0;
        end
    end

    always_ff @(posedge Clock) begin
        if (cipherValid)
            shiftReg <= cipherBucket;
        else if (dramValid)
            shiftReg <= shiftReg >> `ORAM_DRAM_W;   // next beat into the low end
    end

    assign dramData = shiftReg[`ORAM_DRAM_W-1:0];

endmodule

//--- src/oramBucketEncryptor.sv
`timescale 1ns/1ps

module oramBucketEncryptor
    import oramPkg::*;
(
    input  logic        Clock,
    input  logic        rstN,

    input  cipherWord_t cipherKey,

    input  logic        ivValid,
    input  cipherWord_t ivIn,

    input  logic        blockValid,
    input  dataBlock_t  dataIn,
    input  progAddr_t   addrIn,
    input  leafLabel_t  leafIn,

    output logic        dramValid,
    output dramBeat_t   dramData
);

    logic          plainValid;
    plainBucket_t  plainBucket;
    logic          cipherValid;
    cipherBucket_t cipherBucket;

    bucketCollector collector (
        .Clock       (Clock),
        .rstN        (rstN),
        .ivValid     (ivValid),
        .ivIn        (ivIn),
        .blockValid  (blockValid),
        .dataIn      (dataIn),
        .addrIn      (addrIn),
        .leafIn      (leafIn),
        .plainValid  (plainValid),
        .plainBucket (plainBucket)
    );

    bucketCipher cipher (
        .Clock        (Clock),
        .rstN         (rstN),
        .cipherKey    (cipherKey),
        .plainValid   (plainValid),
        .plainBucket  (plainBucket),
        .cipherValid  (cipherValid),
        .cipherBucket (cipherBucket)
    );

    bucketSerializer serializer (
        .Clock        (Clock),
        .rstN         (rstN),
        .cipherValid  (cipherValid),
        .cipherBucket (cipherBucket),
        .dramValid    (dramValid),
        .dramData     (dramData)
    );

endmodule

//--- src/oramPkg.sv
`include "oram_settings.svh"

package oramPkg;

    typedef logic [`ORAM_CIPHER_W-1:0] cipherWord_t;
    typedef logic [`ORAM_BLOCK_W-1:0]  dataBlock_t;
    typedef logic [`ORAM_ADDR_W-1:0]   progAddr_t;
    typedef logic [`ORAM_LEAF_W-1:0]   leafLabel_t;
    typedef logic [`ORAM_DRAM_W-1:0]   dramBeat_t;

    // address in the upper bits
    typedef struct packed {
        progAddr_t  addr;
        leafLabel_t leaf;
    } blockHeader_t;

    typedef struct packed {
        cipherWord_t                            iv;
        blockHeader_t [0:`ORAM_BUCKET_Z-1]      hdr;   // block 0 first
        dataBlock_t   [0:`ORAM_BUCKET_Z-1]      data;
    } plainBucket_t;

    // iv sits at the lsb end, data block 2 at the top
    typedef struct packed {
        dataBlock_t [`ORAM_BUCKET_Z-1:0] data;
        cipherWord_t                     hdrWord;
        cipherWord_t                     iv;
    } cipherBucket_t;

    localparam int          rotAmt     = 13;
    localparam cipherWord_t roundConst = 128'h9e3779b97f4a7c15_f39cc0605cedc835;

    // one round of the stand-in block cipher
    function automatic cipherWord_t cipherRound(cipherWord_t state, cipherWord_t key,
                                                int unsigned round);
        cipherWord_t x;
        x = state ^ key;
        x = (x << rotAmt) | (x >> (`ORAM_CIPHER_W - rotAmt));
        return x + cipherWord_t'(round + 1) * roundConst;
    endfunction

    // full keystream word for one counter value
    function automatic cipherWord_t keystream(cipherWord_t ctr, cipherWord_t key);
        cipherWord_t s;
        s = ctr;
        for (int r = 0; r < `ORAM_ROUNDS; r++) begin
            s = cipherRound(s, key, r);
        end
        return s;
    endfunction

endpackage

//--- verif/oramBucketEncryptorTb.sv
`timescale 1ns/1ps
`include "oram_settings.svh"

module oramBucketEncryptorTb;
    import oramPkg::*;

    localparam int bucketGap   = 16;   // cycles between closing blocks
    localparam int bucketCount = 10;
    localparam int cycleLimit  = bucketCount * 40 + 100;

    logic        Clock;
    logic        rstN;
    cipherWord_t cipherKey;
    logic        ivValid;
    cipherWord_t ivIn;
    logic        blockValid;
    dataBlock_t  dataIn;
    progAddr_t   addrIn;
    leafLabel_t  leafIn;
    logic        dramValid;
    dramBeat_t   dramData;

    int seed = 41;
    int cycles;
    int testCount;
    int errsBefore;

    oramBucketEncryptor dut (.*);

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    function automatic dataBlock_t randomBlock();
        dataBlock_t d;
        for (int w = 0; w < `ORAM_BLOCK_W / 32; w++)
            d[w*32 +: 32] = $random(seed);
        return d;
    endfunction

    task automatic applyReset();
        rstN <= 1'b0;
        repeat (3) @(posedge Clock);
        rstN <= 1'b1;
    endtask

    task automatic loadIv(input cipherWord_t iv);
        @(posedge Clock);
        ivValid <= 1'b1;
        ivIn    <= iv;
        @(posedge Clock);
        ivValid <= 1'b0;
    endtask

    // three back-to-back blocks, optionally with an iv load on the closing one
    task automatic sendBucket(input logic randomData, input logic ivOnLast,
                              input cipherWord_t nextIv);
        for (int b = 0; b < `ORAM_BUCKET_Z; b++) begin
            @(posedge Clock);
            blockValid <= 1'b1;
            dataIn     <= randomData ? randomBlock() : {8{32'hc0de0000 + 32'(b)}};
            addrIn     <= randomData ? progAddr_t'($random(seed)) : progAddr_t'(32'h1000 + b);
            leafIn     <= randomData ? leafLabel_t'($random(seed)) : leafLabel_t'(32'h0a0 + b);
            ivValid    <= ivOnLast && (b == `ORAM_BUCKET_Z - 1);
            ivIn       <= nextIv;
        end
        @(posedge Clock);
        blockValid <= 1'b0;
        ivValid    <= 1'b0;
    endtask

    // until the last expected beat has left the DUT
    task automatic waitDrain();
        do begin
            @(posedge Clock);
        end while (dramValid || dut.chk.expAvail);
    endtask

    task automatic finishTest(input string name);
        testCount++;
        $display("test %0d %s: %0d errors", testCount, name, dut.chk.errCount - errsBefore);
        errsBefore = dut.chk.errCount;
    endtask

    initial begin
        rstN       = 1'b0;
        cipherKey  = 128'h0f1e2d3c4b5a69788796a5b4c3d2e1f0;
        ivValid    = 1'b0;
        ivIn       = '0;
        blockValid = 1'b0;
        dataIn     = '0;
        addrIn     = '0;
        leafIn     = '0;
        testCount  = 0;
        errsBefore = 0;
        applyReset();

        loadIv(128'h00112233445566778899aabbccddeeff);
        sendBucket(1'b0, 1'b0, '0);
        waitDrain();
        finishTest("single bucket");

        // counters wrap past the top of the 128-bit range
        loadIv('1 - 128'd2);
        sendBucket(1'b1, 1'b0, '0);
        waitDrain();
        finishTest("header word");

        for (int k = 0; k < 4; k++) begin
            sendBucket(1'b1, 1'b0, '0);
            if (k < 3)
                repeat (bucketGap - 4) @(posedge Clock);
        end
        waitDrain();
        finishTest("back to back");

        cipherKey <= 128'h5555aaaa_3c3c3c3c_0123abcd_fedc9876;
        loadIv(128'hdeadbeef_00000000_12345678_9abcdef0);
        sendBucket(1'b1, 1'b1, 128'h0badf00d_0badf00d_0badf00d_0badf00d);
        waitDrain();
        sendBucket(1'b1, 1'b0, '0);
        waitDrain();
        finishTest("iv and key reload");

        sendBucket(1'b1, 1'b0, '0);
        wait (dramValid);   // reset lands in the middle of this burst
        @(posedge Clock);
        blockValid <= 1'b1;
        dataIn     <= randomBlock();
        @(posedge Clock);
        blockValid <= 1'b0;
        applyReset();   // partial bucket is dropped
        loadIv(128'h77777777_66666666_55555555_44444444);
        sendBucket(1'b1, 1'b0, '0);
        waitDrain();
        finishTest("reset mid bucket");

        repeat (4) @(posedge Clock);
        $display("%0d tests run, %0d errors", testCount, dut.chk.errCount);
        if (dut.chk.errCount == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < cycleLimit) begin
            @(posedge Clock);
            cycles++;
        end
        $display("timeout: run did not end within %0d cycles", cycleLimit);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- verif/oramBucketEncryptor_assertions.sv
`timescale 1ns/1ps
`include "oram_settings.svh"

module oramBucketEncryptorChecker
    import oramPkg::*;
(
    input logic        Clock,
    input logic        rstN,
    input cipherWord_t cipherKey,
    input logic        ivValid,
    input cipherWord_t ivIn,
    input logic        blockValid,
    input dataBlock_t  dataIn,
    input progAddr_t   addrIn,
    input leafLabel_t  leafIn,
    input logic        dramValid,
    input dramBeat_t   dramData
);

    localparam int laneW = `ORAM_CIPHER_W;

    cipherWord_t ivModel;
    logic [1:0]  blkCnt;
    logic [31:0] hdrs [`ORAM_BUCKET_Z];
    dataBlock_t  blks [`ORAM_BUCKET_Z];
    dramBeat_t   expMem [128];   // room for several buckets in flight
    logic [6:0]  wrPtr;
    logic [6:0]  rdPtr;
    logic [3:0]  beatIdx;
    logic [4:0]  sinceLast;      // saturating
    logic        lastBlk;
    logic        expAvail;
    dramBeat_t   expHead;
    int          errCount = 0;

    assign lastBlk  = blockValid && (blkCnt == 2'(`ORAM_BUCKET_Z - 1));
    assign expAvail = wrPtr != rdPtr;
    assign expHead  = expMem[rdPtr];

    always_ff @(posedge Clock or negedge rstN) begin
        logic [`ORAM_BEATS*`ORAM_DRAM_W-1:0] bkt;
        dataBlock_t  blk;
        cipherWord_t ctr;
        if (!rstN) begin
            ivModel   <= '0;
            blkCnt    <= '0;
            wrPtr     <= '0;
            rdPtr     <= '0;
            beatIdx   <= '0;
            sinceLast <= '1;
        end else begin
            if (ivValid)
                ivModel <= ivIn;
            if (blockValid) begin
                hdrs[blkCnt] <= {addrIn, leafIn};
                blks[blkCnt] <= dataIn;
                blkCnt       <= lastBlk ? 2'd0 : blkCnt + 2'd1;
            end
            if (lastBlk) begin
                // clear iv, header lane from the iv itself, data lanes from iv + 1 on
                bkt[laneW-1:0] = ivModel;
                bkt[2*laneW-1:laneW] = {32'h0, addrIn, leafIn, hdrs[1], hdrs[0]}
                                       ^ keystream(ivModel, cipherKey);
                for (int i = 0; i < `ORAM_BUCKET_Z; i++) begin
                    blk = (i == `ORAM_BUCKET_Z - 1) ? dataIn : blks[i];
                    for (int j = 0; j < 2; j++) begin
                        ctr = ivModel + cipherWord_t'(1 + 2*i + j);
                        bkt[(2 + 2*i + j)*laneW +: laneW] =
                            blk[j*laneW +: laneW] ^ keystream(ctr, cipherKey);
                    end
                end
                for (int b = 0; b < `ORAM_BEATS; b++)
                    expMem[wrPtr + 7'(b)] <= bkt[b*`ORAM_DRAM_W +: `ORAM_DRAM_W];
                wrPtr <= wrPtr + 7'(`ORAM_BEATS);
            end
            if (dramValid) begin
                rdPtr   <= rdPtr + 7'd1;
                beatIdx <= beatIdx + 4'd1;
            end
            sinceLast <= lastBlk ? 5'd0 : (sinceLast == '1 ? sinceLast : sinceLast + 5'd1);
        end
    end

    beatValue: assert property (@(posedge Clock) disable iff (!rstN)
        dramValid |-> expAvail && dramData == expHead)
        else begin
            $error("FAILED at %0t ns: dramData expected %h, got %h (beat outstanding %0b)",
                   $time, $sampled(expHead), $sampled(dramData), $sampled(expAvail));
            errCount++;
        end

    firstBeatLatency: assert property (@(posedge Clock) disable iff (!rstN)
        $past(lastBlk, 6) |-> dramValid && beatIdx == 4'd0)
        else begin
            $error("first beat did not come 6 cycles after the closing block");
            errCount++;
        end

    burstLength: assert property (@(posedge Clock) disable iff (!rstN)
        $fell(dramValid) |-> beatIdx == 4'd0)
        else begin
            $error("dramValid burst ended before 16 beats");
            errCount++;
        end

    quietInReset: assert property (@(posedge Clock) !rstN |-> !dramValid)
        else begin
            $error("dramValid was high during reset");
            errCount++;
        end

    bucketSpacing: assert property (@(posedge Clock) disable iff (!rstN)
        lastBlk |-> sinceLast >= 5'd15)
        else begin
            $error("closing blocks of two buckets came less than 16 cycles apart");
            errCount++;
        end

endmodule

bind oramBucketEncryptor oramBucketEncryptorChecker chk (
    .Clock      (Clock),
    .rstN       (rstN),
    .cipherKey  (cipherKey),
    .ivValid    (ivValid),
    .ivIn       (ivIn),
    .blockValid (blockValid),
    .dataIn     (dataIn),
    .addrIn     (addrIn),
    .leafIn     (leafIn),
    .dramValid  (dramValid),
    .dramData   (dramData)
);
